// ==== build.f ====
pipe_pkg.sv
write_fifo.sv
fifo_bram.sv
read_fifo.sv
line_buffer.sv
tb_line_buffer.sv

// ==== fifo_bram.sv ====
`timescale 1ns/1ps

module fifo_bram
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6,
    parameter int AF_MARGIN  = 4
)
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  mem_we,
    input  logic [DATA_WIDTH-1:0] mem_wdata,

    input  logic                  mem_re,
    output logic [DATA_WIDTH-1:0] mem_rdata,

    output logic                  mem_empty,
    output logic                  mem_almostfull
);
    localparam int DEPTH = 1 << ADDR_WIDTH;

    // Occupancy thresholds at counter width.
    localparam logic [ADDR_WIDTH:0] FULL_CNT = (ADDR_WIDTH+1)'(DEPTH);
    localparam logic [ADDR_WIDTH:0] AF_CNT   = (ADDR_WIDTH+1)'(DEPTH - AF_MARGIN);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic [ADDR_WIDTH:0]   count_next;

    logic do_write;
    logic do_read;

    // Writes when full and reads when empty are dropped.
    assign do_write = mem_we && (count != FULL_CNT);
    assign do_read  = mem_re && (count != '0);

    // ==================================================
    // Storage and registered read port
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= mem_wdata;
        end
        if (do_read)
        begin
            mem_rdata <= mem[rd_ptr];
        end
    end

    // ==================================================
    // Pointers, occupancy and flags
    // ==================================================

    always_comb
    begin
        case ({do_write, do_read})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            mem_empty      <= 1'b1;
            mem_almostfull <= 1'b0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count          <= count_next;
            mem_empty      <= (count_next == '0);
            mem_almostfull <= (count_next >= AF_CNT);
        end
    end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6,
    parameter int AF_MARGIN  = 4
)
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           op_start,
    input  logic [pipe_pkg::CFG_WIDTH-1:0] cfg,

    input  logic                           in_we,
    input  logic [DATA_WIDTH-1:0]          in_data,
    output logic                           in_almostfull,

    input  logic                           out_almostfull,
    output logic                           out_we,
    output logic [DATA_WIDTH-1:0]          out_data,

    output logic                           op_done
);
    logic                  mem_we;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic                  mem_re;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic                  mem_empty;

    // ==================================================
    // Write side, memory, read side
    // ==================================================

    write_fifo #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_write_fifo (
        .clk       (clk),
        .reset     (reset),
        .op_start  (op_start),
        .cfg       (cfg),
        .in_we     (in_we),
        .in_data   (in_data),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata)
    );

    // Almost-full goes straight back upstream.
    fifo_bram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .AF_MARGIN  (AF_MARGIN)
    ) i_fifo_bram (
        .clk            (clk),
        .reset          (reset),
        .mem_we         (mem_we),
        .mem_wdata      (mem_wdata),
        .mem_re         (mem_re),
        .mem_rdata      (mem_rdata),
        .mem_empty      (mem_empty),
        .mem_almostfull (in_almostfull)
    );

    read_fifo #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_read_fifo (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .cfg            (cfg),
        .mem_empty      (mem_empty),
        .mem_rdata      (mem_rdata),
        .mem_re         (mem_re),
        .out_almostfull (out_almostfull),
        .out_we         (out_we),
        .out_data       (out_data),
        .op_done        (op_done)
    );

endmodule

// ==== line_buffer_trace.txt ====
# One operation per line: code(hex) wlen rlen push bp in_almostfull
# bp 0 keeps out_almostfull low, bp 1 toggles it from LFSR bits.
# Ordering, equal write and read lengths.
01 16 16 16 0 0
02 1 1 1 0 0
03 40 40 40 0 0
# Write truncation, surplus pushes are dropped.
04 8 8 12 0 0
05 8 8 8 0 0
06 4 4 9 0 0
07 5 5 5 0 0
# Zero lengths.
08 0 0 0 0 0
09 10 10 10 0 0
0a 0 0 0 0 0
0b 0 0 5 0 0
0c 3 3 3 0 0
# Back-pressure from downstream.
0d 32 32 32 1 0
0e 24 24 24 1 0
0f 48 48 48 1 0
10 6 6 9 1 0
# Almost-full threshold, then drain.
11 60 0 60 0 1
12 0 60 0 0 0
13 59 0 59 0 0
14 0 59 0 0 0
# Split reads.
16 20 12 20 0 0
17 0 8 0 0 0
18 16 5 16 1 0
19 0 11 0 1 0
1a 30 10 30 0 0
1b 0 10 0 1 0
1c 0 10 0 0 0
# Mixed operations at the end.
1d 12 12 12 1 0
1e 2 2 2 0 0
1f 7 3 7 0 0
20 0 4 0 1 0
21 9 9 9 0 0
22 0 0 0 0 0
23 14 14 14 1 0

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // ==================================================
    // Line counts
    // ==================================================

    // Width of a length field and of the line counters.
    localparam int LEN_WIDTH = 16;

    // Unsigned line count for write and read lengths.
    typedef logic [LEN_WIDTH-1:0] len_t;

    // ==================================================
    // Configuration word
    // ==================================================

    // Width of the configuration word.
    localparam int CFG_WIDTH = 32;

    // Write length sits in bits 31..16.
    localparam int WLEN_LSB = 16;

    // Read length sits in bits 15..0.
    localparam int RLEN_LSB = 0;

endpackage

// ==== read_fifo.sv ====
`timescale 1ns/1ps

module read_fifo
#(
    parameter int DATA_WIDTH = 32
)
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           op_start,
    input  logic [pipe_pkg::CFG_WIDTH-1:0] cfg,

    input  logic                           mem_empty,
    input  logic [DATA_WIDTH-1:0]          mem_rdata,
    output logic                           mem_re,

    input  logic                           out_almostfull,
    output logic                           out_we,
    output logic [DATA_WIDTH-1:0]          out_data,

    output logic                           op_done
);
    import pipe_pkg::*;

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_SEND = 1'b1;

    logic state;

    len_t remaining;
    len_t cfg_rlen;
    logic pop;

    // Lower field of the configuration word.
    assign cfg_rlen = cfg[RLEN_LSB +: LEN_WIDTH];

    // Pop only with data present and room downstream.
    assign pop = (state == ST_SEND) && (remaining != '0)
                 && !mem_empty && !out_almostfull;

    assign mem_re = pop;

    // Read data arrives together with the delayed pop.
    assign out_data = mem_rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= ST_IDLE;
            remaining <= '0;
            out_we    <= 1'b0;
            op_done   <= 1'b0;
        end
        else
        begin
            out_we  <= pop;
            op_done <= pop && (remaining == len_t'(1));

            case (state)
                ST_IDLE:
                begin
                    if (op_start && cfg_rlen != '0)
                    begin
                        remaining <= cfg_rlen;
                        state     <= ST_SEND;
                    end
                end

                ST_SEND:
                begin
                    if (pop)
                    begin
                        remaining <= remaining - len_t'(1);
                    end
                    // Back to idle once the final line has left.
                    if (op_done)
                    begin
                        state <= ST_IDLE;
                    end
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the line_buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f build.f \
    --top-module tb_line_buffer \
    -o sim_line_buffer

./obj_dir/sim_line_buffer > sim.log 2>&1
cat sim.log

if grep -q -F "*** PASSED ***" sim.log
then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

// ==== tb_line_buffer.sv ====
`timescale 1ns/1ps

module tb_line_buffer;
    import pipe_pkg::*;

    localparam int          CLK_HALF   = 2;
    localparam int          DATA_WIDTH = 32;
    localparam int          MAX_OPS    = 64;
    localparam string       TRACE_FILE = "line_buffer_trace.txt";
    localparam logic [31:0] LFSR_SEED  = 32'ha6b772dd;

    logic                  clk;
    logic                  reset;
    logic                  op_start;
    logic [CFG_WIDTH-1:0]  cfg;
    logic                  in_we;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_almostfull;
    logic                  out_almostfull;
    logic                  out_we;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  op_done;

    // Trace contents per operation.
    int t_code [MAX_OPS];
    int t_wlen [MAX_OPS];
    int t_rlen [MAX_OPS];
    int t_push [MAX_OPS];
    int t_bp   [MAX_OPS];
    int t_af   [MAX_OPS];
    int n_ops;

    logic [DATA_WIDTH-1:0] expected_q [$];
    logic [31:0]           lfsr_state;

    bit trace_ok;
    bit bp_mode;
    int errors;
    int tests_passed;
    int tests_failed;
    int test_out;
    int test_done;
    int cur_rlen;
    int af_run;
    int cycles;
    int cycle_limit;

    line_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (6),
        .AF_MARGIN  (4)
    ) i_line_buffer (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .cfg            (cfg),
        .in_we          (in_we),
        .in_data        (in_data),
        .in_almostfull  (in_almostfull),
        .out_almostfull (out_almostfull),
        .out_we         (out_we),
        .out_data       (out_data),
        .op_done        (op_done)
    );

    always #CLK_HALF clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    // Inputs change 1 ns after the next edge.
    task automatic tick();
        logic [31:0] bits;
        @(posedge clk);
        #1;
        if (bp_mode)
        begin
            draw_bits(1, bits);
            out_almostfull = bits[0];
        end
        else
        begin
            out_almostfull = 1'b0;
        end
    endtask

    task automatic load_trace(output bit ok);
        int    fd;
        int    fields;
        int    code;
        int    wlen;
        int    rlen;
        int    push;
        int    bp;
        int    af;
        string line;
        ok    = 1'b0;
        n_ops = 0;
        fd    = $fopen(TRACE_FILE, "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%h %d %d %d %d %d", code, wlen, rlen, push, bp, af);
                    if (fields == 6 && n_ops < MAX_OPS)
                    begin
                        t_code[n_ops] = code;
                        t_wlen[n_ops] = wlen;
                        t_rlen[n_ops] = rlen;
                        t_push[n_ops] = push;
                        t_bp[n_ops]   = bp;
                        t_af[n_ops]   = af;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
            ok = (n_ops > 0);
        end
    endtask

    // ==================================================
    // One operation from the trace
    // ==================================================

    task automatic run_op(input int t);
        logic [31:0] word;
        int          errors_before;
        errors_before = errors;
        cur_rlen      = t_rlen[t];
        test_out      = 0;
        test_done     = 0;
        bp_mode       = (t_bp[t] != 0);

        op_start = 1'b1;
        cfg      = '0;
        cfg[WLEN_LSB +: LEN_WIDTH] = len_t'(t_wlen[t]);
        cfg[RLEN_LSB +: LEN_WIDTH] = len_t'(t_rlen[t]);
        tick();
        op_start = 1'b0;
        cfg      = '0;

        // Only the first wlen pushes are kept.
        for (int i = 0; i < t_push[t]; i++)
        begin
            draw_bits(DATA_WIDTH, word);
            in_we   = 1'b1;
            in_data = word;
            if (i < t_wlen[t])
            begin
                expected_q.push_back(word);
            end
            tick();
        end
        in_we   = 1'b0;
        in_data = '0;

        repeat (4) tick();
        check_value("in_almostfull", in_almostfull, t_af[t]);

        while (test_out < cur_rlen)
        begin
            tick();
        end
        bp_mode = 1'b0;
        repeat (6) tick();

        check_value("out_we count", test_out, cur_rlen);
        check_value("op_done count", test_done, (cur_rlen != 0) ? 1 : 0);

        if (errors == errors_before)
        begin
            tests_passed++;
            $display("test %02h wlen %0d rlen %0d push %0d: ok",
                     t_code[t], t_wlen[t], t_rlen[t], t_push[t]);
        end
        else
        begin
            tests_failed++;
            $display("test %02h wlen %0d rlen %0d push %0d: %0d errors",
                     t_code[t], t_wlen[t], t_rlen[t], t_push[t], errors - errors_before);
        end
    endtask

    // ==================================================
    // Output monitor and cycle limit
    // ==================================================

    always @(posedge clk)
    begin
        if (reset)
        begin
            af_run = 0;
        end
        else
        begin
            if (out_we)
            begin
                if (af_run > 2)
                begin
                    $display("ERROR: out_we while out_almostfull was high for %0d cycles",
                             af_run);
                    errors++;
                end
                if (expected_q.size() == 0)
                begin
                    $display("ERROR: out_we with no line left in the expected queue");
                    errors++;
                end
                else
                begin
                    check_value("out_data", out_data, expected_q.pop_front());
                end
                test_out++;
            end
            if (op_done)
            begin
                test_done++;
                if (!out_we)
                begin
                    $display("ERROR: op_done pulsed without out_we");
                    errors++;
                end
                check_value("lines at op_done", test_out, cur_rlen);
            end
            af_run = out_almostfull ? af_run + 1 : 0;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("ERROR: run stopped by timeout after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        op_start       = 1'b0;
        cfg            = '0;
        in_we          = 1'b0;
        in_data        = '0;
        out_almostfull = 1'b0;
        bp_mode        = 1'b0;
        lfsr_state     = LFSR_SEED;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cycles         = 0;
        cycle_limit    = 0;

        load_trace(trace_ok);
        if (!trace_ok)
        begin
            $display("ERROR: could not read any operation from %s", TRACE_FILE);
            $display("*** FAILED ***");
            $finish;
        end
        else
        begin
            cycle_limit = 200;
            for (int t = 0; t < n_ops; t++)
            begin
                cycle_limit += 40 * (t_push[t] + t_rlen[t]);
            end

            tick();
            tick();
            reset = 1'b0;

            for (int t = 0; t < n_ops; t++)
            begin
                run_op(t);
            end
            check_value("lines left", expected_q.size(), 0);

            $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
            if (errors == 0 && tests_failed == 0)
            begin
                $display("*** PASSED ***");
            end
            else
            begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// ==== write_fifo.sv ====
`timescale 1ns/1ps

module write_fifo
#(
    parameter int DATA_WIDTH = 32
)
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           op_start,
    input  logic [pipe_pkg::CFG_WIDTH-1:0] cfg,

    input  logic                           in_we,
    input  logic [DATA_WIDTH-1:0]          in_data,

    output logic                           mem_we,
    output logic [DATA_WIDTH-1:0]          mem_wdata
);
    import pipe_pkg::*;

    localparam logic ST_IDLE    = 1'b0;
    localparam logic ST_RECEIVE = 1'b1;

    logic state;

    len_t wr_length;
    len_t rx_count;
    len_t cfg_wlen;

    // Upper field of the configuration word.
    assign cfg_wlen = cfg[WLEN_LSB +: LEN_WIDTH];

    always_ff @(posedge clk)
    begin
        mem_wdata <= in_data;

        if (reset)
        begin
            state    <= ST_IDLE;
            mem_we   <= 1'b0;
            rx_count <= '0;
        end
        else
        begin
            mem_we <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (op_start)
                    begin
                        wr_length <= cfg_wlen;
                        rx_count  <= '0;
                        if (cfg_wlen != '0)
                        begin
                            state <= ST_RECEIVE;
                        end
                    end
                end

                ST_RECEIVE:
                begin
                    if (in_we && rx_count < wr_length)
                    begin
                        mem_we   <= 1'b1;
                        rx_count <= rx_count + len_t'(1);
                        // Writes after the last line are dropped.
                        if (rx_count == wr_length - len_t'(1))
                        begin
                            state <= ST_IDLE;
                        end
                    end
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule
